// File: filelist.f
source/ptp_const_pkg.sv
source/ptp_types_pkg.sv
source/ptp_adj_ctrl.sv
source/ptp_tod_counter.sv
source/ptp_ns_counter.sv
source/ptp_pps_out.sv
source/ptp_clock_top.sv
tb/ptp_clock_assert.sv
tb/ptp_clock_tb.sv

// File: source/ptp_adj_ctrl.sv
// PTP clock increment control
// latches period, offset and drift commands
// offset FSM counting down the adjust cycles
// drift counter and the registered per-cycle increment

`timescale 1ns/1ps

module ptp_adj_ctrl #(
    parameter logic [ptp_const_pkg::PERIOD_NS_W-1:0] PERIOD_NS = 4'h6,
    parameter logic [ptp_const_pkg::FNS_W-1:0]       PERIOD_FNS = 16'h6666,
    parameter bit                                    DRIFT_ENABLE = 1'b1,
    parameter logic [ptp_const_pkg::DRIFT_NS_W-1:0]  DRIFT_NS = 4'h0,
    parameter logic [ptp_const_pkg::FNS_W-1:0]       DRIFT_FNS = 16'h0002,
    parameter logic [ptp_const_pkg::CNT_W-1:0]       DRIFT_RATE = 16'd5
) (
    input  logic                            clk,
    input  logic                            rst,
    input  ptp_types_pkg::ptp_period_cmd_t  period_cmd,
    input  ptp_types_pkg::ptp_adj_cmd_t     adj_cmd,
    input  ptp_types_pkg::ptp_drift_cmd_t   drift_cmd,
    output ptp_types_pkg::ptp_inc_t         inc,
    output logic                            adj_active
);

    localparam int INC_W = ptp_const_pkg::INC_NS_W + ptp_const_pkg::FNS_W;

    logic [ptp_const_pkg::PERIOD_NS_W-1:0]        period_ns_q;
    logic [ptp_const_pkg::FNS_W-1:0]              period_fns_q;
    logic signed [ptp_const_pkg::OFFSET_NS_W-1:0] adj_ns_q;
    logic [ptp_const_pkg::FNS_W-1:0]              adj_fns_q;
    logic [ptp_const_pkg::CNT_W-1:0]              adj_cnt_q;
    ptp_types_pkg::adj_state_e                    state_q;
    logic [ptp_const_pkg::DRIFT_NS_W-1:0]         drift_ns_q;
    logic [ptp_const_pkg::FNS_W-1:0]              drift_fns_q;
    logic [ptp_const_pkg::CNT_W-1:0]              drift_rate_q;
    logic [ptp_const_pkg::CNT_W-1:0]              drift_cnt_q;

    logic [INC_W-1:0] period_term;
    logic [INC_W-1:0] adj_term;
    logic [INC_W-1:0] drift_term;

    assign adj_active = (state_q == ptp_types_pkg::ADJ_ACTIVE);

    // period and drift are unsigned while the offset is sign extended
    assign period_term = {{(ptp_const_pkg::INC_NS_W - ptp_const_pkg::PERIOD_NS_W){1'b0}},
                          period_ns_q, period_fns_q};
    assign adj_term = adj_active ?
        {{(ptp_const_pkg::INC_NS_W - ptp_const_pkg::OFFSET_NS_W){adj_ns_q[ptp_const_pkg::OFFSET_NS_W-1]}},
         adj_ns_q, adj_fns_q} : '0;
    assign drift_term = (DRIFT_ENABLE && drift_cnt_q == '0) ?
        {{(ptp_const_pkg::INC_NS_W - ptp_const_pkg::DRIFT_NS_W){1'b0}},
         drift_ns_q, drift_fns_q} : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            period_ns_q <= PERIOD_NS;
            period_fns_q <= PERIOD_FNS;
            drift_ns_q <= DRIFT_NS;
            drift_fns_q <= DRIFT_FNS;
            drift_rate_q <= DRIFT_RATE;
            drift_cnt_q <= '0;
            adj_cnt_q <= '0;
            state_q <= ptp_types_pkg::ADJ_IDLE;
            inc <= '0;
        end else begin
            inc <= period_term + adj_term + drift_term;

            if (period_cmd.valid) begin
                period_ns_q <= period_cmd.ns;
                period_fns_q <= period_cmd.fns;
            end

            if (DRIFT_ENABLE && drift_cmd.valid) begin
                drift_ns_q <= drift_cmd.ns;
                drift_fns_q <= drift_cmd.fns;
                drift_rate_q <= drift_cmd.rate;
            end

            // drift applied on the cycle the counter hits zero
            if (drift_cnt_q == '0) begin
                drift_cnt_q <= drift_rate_q - 1'b1;
            end else begin
                drift_cnt_q <= drift_cnt_q - 1'b1;
            end

            // one active cycle per remaining count
            case (state_q)
                ptp_types_pkg::ADJ_IDLE: begin
                    if (adj_cnt_q != '0) begin
                        state_q <= ptp_types_pkg::ADJ_ACTIVE;
                        adj_cnt_q <= adj_cnt_q - 1'b1;
                    end
                end
                ptp_types_pkg::ADJ_ACTIVE: begin
                    if (adj_cnt_q == '0) begin
                        state_q <= ptp_types_pkg::ADJ_IDLE;
                    end else begin
                        adj_cnt_q <= adj_cnt_q - 1'b1;
                    end
                end
                default: state_q <= ptp_types_pkg::ADJ_IDLE;
            endcase

            // new command restarts the count
            if (adj_cmd.valid) begin
                adj_cnt_q <= adj_cmd.count;
            end
        end
    end

    // offset held for the adjust window
    always_ff @(posedge clk) begin
        if (adj_cmd.valid) begin
            adj_ns_q <= adj_cmd.ns;
            adj_fns_q <= adj_cmd.fns;
        end
    end

endmodule

// File: source/ptp_clock_top.sv
// PTP hardware clock top level
// increment control feeding the time-of-day and ns counters
// output stage with PPS, step flag and timestamps

`timescale 1ns/1ps

module ptp_clock_top #(
    parameter logic [ptp_const_pkg::PERIOD_NS_W-1:0] PERIOD_NS = 4'h6,
    parameter logic [ptp_const_pkg::FNS_W-1:0]       PERIOD_FNS = 16'h6666,
    parameter bit                                    DRIFT_ENABLE = 1'b1,
    parameter logic [ptp_const_pkg::DRIFT_NS_W-1:0]  DRIFT_NS = 4'h0,
    parameter logic [ptp_const_pkg::FNS_W-1:0]       DRIFT_FNS = 16'h0002,
    parameter logic [ptp_const_pkg::CNT_W-1:0]       DRIFT_RATE = 16'd5,
    parameter int                                    PPS_WIDTH = 16
) (
    input  logic                            clk,
    input  logic                            rst,
    input  ptp_types_pkg::ptp_period_cmd_t  period_cmd,
    input  ptp_types_pkg::ptp_adj_cmd_t     adj_cmd,
    input  ptp_types_pkg::ptp_drift_cmd_t   drift_cmd,
    input  ptp_types_pkg::ptp_ts96_load_t   ts96_load,
    input  ptp_types_pkg::ptp_ts64_load_t   ts64_load,
    output ptp_types_pkg::ptp_ts96_t        ts96,
    output ptp_types_pkg::ptp_ts64_t        ts64,
    output logic                            ts_step,
    output logic                            pps,
    output logic                            adj_active
);

    ptp_types_pkg::ptp_inc_t  inc;
    ptp_types_pkg::ptp_ts96_t tod;
    ptp_types_pkg::ptp_ts64_t ns_time;
    logic                     sec_rollover;
    logic                     tod_loaded;
    logic                     ns_loaded;

    ptp_adj_ctrl #(
        .PERIOD_NS    (PERIOD_NS),
        .PERIOD_FNS   (PERIOD_FNS),
        .DRIFT_ENABLE (DRIFT_ENABLE),
        .DRIFT_NS     (DRIFT_NS),
        .DRIFT_FNS    (DRIFT_FNS),
        .DRIFT_RATE   (DRIFT_RATE)
    ) u_ptp_adj_ctrl (
        .clk        (clk),
        .rst        (rst),
        .period_cmd (period_cmd),
        .adj_cmd    (adj_cmd),
        .drift_cmd  (drift_cmd),
        .inc        (inc),
        .adj_active (adj_active)
    );

    // both counters step on the same increment
    ptp_tod_counter u_ptp_tod_counter (
        .clk          (clk),
        .rst          (rst),
        .inc          (inc),
        .load         (ts96_load),
        .tod          (tod),
        .sec_rollover (sec_rollover),
        .loaded       (tod_loaded)
    );

    ptp_ns_counter u_ptp_ns_counter (
        .clk     (clk),
        .rst     (rst),
        .inc     (inc),
        .load    (ts64_load),
        .ns_time (ns_time),
        .loaded  (ns_loaded)
    );

    ptp_pps_out #(
        .PPS_WIDTH (PPS_WIDTH)
    ) u_ptp_pps_out (
        .clk          (clk),
        .rst          (rst),
        .tod          (tod),
        .ns_time      (ns_time),
        .sec_rollover (sec_rollover),
        .tod_loaded   (tod_loaded),
        .ns_loaded    (ns_loaded),
        .adj_active   (adj_active),
        .ts96         (ts96),
        .ts64         (ts64),
        .ts_step      (ts_step),
        .pps          (pps)
    );

endmodule

// File: source/ptp_const_pkg.sv
// PTP clock constants
// fixed-point split shared by every time value
// command field widths for period, offset and drift
// counter field widths of both time-of-day formats
// nanosecond wrap point of the seconds counter

package ptp_const_pkg;

    // fractional nanoseconds, fixed by the output formats
    localparam int FNS_W = 16;

    // integer nanosecond parts of the increment sources
    localparam int PERIOD_NS_W = 4;
    localparam int OFFSET_NS_W = 4;
    localparam int DRIFT_NS_W = 4;

    // headroom for period + offset + drift
    localparam int INC_NS_W = 6;

    // offset cycle count and drift rate
    localparam int CNT_W = 16;

    // 96-bit format: seconds, pad, nanoseconds, fraction
    localparam int SEC_W = 48;
    localparam int TS_PAD_W = 2;
    localparam int TOD_NS_W = 30;

    // 64-bit format: nanoseconds, fraction
    localparam int NS64_W = 48;

    // ns field wraps here and carries into seconds
    localparam int unsigned NS_PER_SEC = 1_000_000_000;

endpackage

// File: source/ptp_ns_counter.sv
// PTP free-running nanosecond counter
// 48-bit ns with 16-bit fraction, accumulates the increment
// direct load with a one-cycle load pulse

`timescale 1ns/1ps

module ptp_ns_counter (
    input  logic                           clk,
    input  logic                           rst,
    input  ptp_types_pkg::ptp_inc_t        inc,
    input  ptp_types_pkg::ptp_ts64_load_t  load,
    output ptp_types_pkg::ptp_ts64_t       ns_time,
    output logic                           loaded
);

    localparam int TS_W = $bits(ptp_types_pkg::ptp_ts64_t);
    localparam int INC_W = $bits(ptp_types_pkg::ptp_inc_t);

    logic [TS_W-1:0] acc_q;
    logic [TS_W-1:0] inc_ext;

    assign inc_ext = {{(TS_W - INC_W){1'b0}}, inc};

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_q <= '0;
            loaded <= 1'b0;
        end else begin
            loaded <= load.valid;
            if (load.valid) begin
                acc_q <= load.ts;
            end else begin
                // free-running sum of the increment
                acc_q <= acc_q + inc_ext;
            end
        end
    end

    assign ns_time = acc_q;

endmodule

// File: source/ptp_pps_out.sv
// PTP clock output stage
// PPS pulse stretched from the seconds rollover
// step flag from loads and offset adjust
// registered 96-bit and 64-bit output timestamps

`timescale 1ns/1ps

module ptp_pps_out #(
    parameter int PPS_WIDTH = 16
) (
    input  logic                      clk,
    input  logic                      rst,
    input  ptp_types_pkg::ptp_ts96_t  tod,
    input  ptp_types_pkg::ptp_ts64_t  ns_time,
    input  logic                      sec_rollover,
    input  logic                      tod_loaded,
    input  logic                      ns_loaded,
    input  logic                      adj_active,
    output ptp_types_pkg::ptp_ts96_t  ts96,
    output ptp_types_pkg::ptp_ts64_t  ts64,
    output logic                      ts_step,
    output logic                      pps
);

    localparam int CNT_W = (PPS_WIDTH > 1) ? $clog2(PPS_WIDTH) : 1;

    logic [CNT_W-1:0] pps_cnt_q;
    logic             load_step_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pps <= 1'b0;
            pps_cnt_q <= '0;
            load_step_q <= 1'b0;
            ts96 <= '0;
            ts64 <= '0;
        end else begin
            // rollover during a pulse restarts it
            if (sec_rollover) begin
                pps <= 1'b1;
                pps_cnt_q <= CNT_W'(PPS_WIDTH - 1);
            end else if (pps_cnt_q != '0) begin
                pps_cnt_q <= pps_cnt_q - 1'b1;
            end else begin
                pps <= 1'b0;
            end

            load_step_q <= tod_loaded | ns_loaded;

            ts96 <= '{sec: tod.sec, pad: '0, ns: tod.ns, fns: tod.fns};
            ts64 <= ns_time;
        end
    end

    // offset step follows adj_active cycle for cycle
    assign ts_step = load_step_q | adj_active;

endmodule

// File: source/ptp_tod_counter.sv
// PTP time-of-day counter
// 48-bit seconds, 30-bit ns, 16-bit fraction
// one-second lookahead register for the rollover decision
// direct load, rollover and load pulses

`timescale 1ns/1ps

module ptp_tod_counter (
    input  logic                           clk,
    input  logic                           rst,
    input  ptp_types_pkg::ptp_inc_t        inc,
    input  ptp_types_pkg::ptp_ts96_load_t  load,
    output ptp_types_pkg::ptp_ts96_t       tod,
    output logic                           sec_rollover,
    output logic                           loaded
);

    localparam int TIME_W = ptp_const_pkg::TOD_NS_W + ptp_const_pkg::FNS_W;
    localparam int OVF_W = TIME_W + 1;
    localparam int INC_W = $bits(ptp_types_pkg::ptp_inc_t);
    localparam logic [OVF_W-1:0] ONE_SEC =
        OVF_W'(ptp_const_pkg::NS_PER_SEC) << ptp_const_pkg::FNS_W;

    logic [ptp_const_pkg::SEC_W-1:0] sec_q;
    logic [TIME_W-1:0]               time_q;
    // time_q minus one second, msb set while it borrows
    logic [OVF_W-1:0]                ovf_q;

    logic [TIME_W-1:0] inc_ext;
    logic [TIME_W-1:0] sum;
    logic [OVF_W-1:0]  sum_ovf;
    logic [TIME_W-1:0] load_time;
    logic              wrap;

    assign inc_ext = {{(TIME_W - INC_W){1'b0}}, inc};
    assign load_time = {load.ts.ns, load.ts.fns};

    // both paths are one adder deep
    assign sum = time_q + inc_ext;
    assign sum_ovf = ovf_q + {1'b0, inc_ext};
    assign wrap = ~sum_ovf[OVF_W-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            sec_q <= '0;
            time_q <= '0;
            ovf_q <= '0 - ONE_SEC;
            sec_rollover <= 1'b0;
            loaded <= 1'b0;
        end else begin
            loaded <= load.valid;
            sec_rollover <= 1'b0;
            if (load.valid) begin
                sec_q <= load.ts.sec;
                time_q <= load_time;
                ovf_q <= {1'b0, load_time} - ONE_SEC;
            end else if (wrap) begin
                // sum reached one second, carry into seconds
                sec_q <= sec_q + 1'b1;
                time_q <= sum_ovf[TIME_W-1:0];
                ovf_q <= sum_ovf - ONE_SEC;
                sec_rollover <= 1'b1;
            end else begin
                time_q <= sum;
                ovf_q <= sum_ovf;
            end
        end
    end

    assign tod = '{
        sec: sec_q,
        pad: '0,
        ns:  time_q[TIME_W-1 -: ptp_const_pkg::TOD_NS_W],
        fns: time_q[ptp_const_pkg::FNS_W-1:0]
    };

endmodule

// File: source/ptp_types_pkg.sv
// PTP clock types
// per-cycle increment and the three adjustment commands
// 96-bit and 64-bit timestamps with their load strobes
// offset-adjust state encoding

package ptp_types_pkg;

    typedef struct packed {
        logic [ptp_const_pkg::INC_NS_W-1:0] ns;
        logic [ptp_const_pkg::FNS_W-1:0]    fns;
    } ptp_inc_t;

    typedef struct packed {
        logic                                  valid;
        logic [ptp_const_pkg::PERIOD_NS_W-1:0] ns;
        logic [ptp_const_pkg::FNS_W-1:0]       fns;
    } ptp_period_cmd_t;

    // two's complement offset, ns and fns form one signed value
    typedef struct packed {
        logic                                         valid;
        logic signed [ptp_const_pkg::OFFSET_NS_W-1:0] ns;
        logic [ptp_const_pkg::FNS_W-1:0]              fns;
        logic [ptp_const_pkg::CNT_W-1:0]              count;
    } ptp_adj_cmd_t;

    typedef struct packed {
        logic                                 valid;
        logic [ptp_const_pkg::DRIFT_NS_W-1:0] ns;
        logic [ptp_const_pkg::FNS_W-1:0]      fns;
        logic [ptp_const_pkg::CNT_W-1:0]      rate;
    } ptp_drift_cmd_t;

    typedef struct packed {
        logic [ptp_const_pkg::SEC_W-1:0]    sec;
        logic [ptp_const_pkg::TS_PAD_W-1:0] pad;
        logic [ptp_const_pkg::TOD_NS_W-1:0] ns;
        logic [ptp_const_pkg::FNS_W-1:0]    fns;
    } ptp_ts96_t;

    typedef struct packed {
        logic [ptp_const_pkg::NS64_W-1:0] ns;
        logic [ptp_const_pkg::FNS_W-1:0]  fns;
    } ptp_ts64_t;

    typedef struct packed {
        logic      valid;
        ptp_ts96_t ts;
    } ptp_ts96_load_t;

    typedef struct packed {
        logic      valid;
        ptp_ts64_t ts;
    } ptp_ts64_load_t;

    typedef enum logic [0:0] {
        ADJ_IDLE   = 1'b0,
        ADJ_ACTIVE = 1'b1
    } adj_state_e;

endpackage

// File: tb/ptp_clock_assert.sv
// PTP clock assertions bound to the top level
// pps pulse length, ns range of ts96, sources of the step flag

`timescale 1ns/1ps

module ptp_clock_assert #(
    parameter int PPS_WIDTH = 16
) (
    input logic                     clk,
    input logic                     rst,
    input ptp_types_pkg::ptp_ts96_t ts96,
    input logic                     pps,
    input logic                     ts_step,
    input logic                     adj_active,
    input logic                     ts96_load_valid,
    input logic                     ts64_load_valid
);

    // failed assertions so far
    int unsigned fail_cnt = 0;
    // consecutive high pps cycles before this one
    int unsigned pps_run;

    always_ff @(posedge clk) begin
        if (rst || !pps) begin
            pps_run <= 0;
        end else begin
            pps_run <= pps_run + 1;
        end
    end

    pps_width_limit: assert property (@(posedge clk) disable iff (rst)
        pps |-> pps_run < PPS_WIDTH)
        else begin
            $error("pps high for more than %0d cycles", PPS_WIDTH);
            fail_cnt++;
        end

    ns_in_range: assert property (@(posedge clk) disable iff (rst)
        ts96.ns < ptp_const_pkg::NS_PER_SEC)
        else begin
            $error("ts96 ns reached one second: %0d", ts96.ns);
            fail_cnt++;
        end

    // outside an offset window only a load strobe two edges earlier raises the step flag
    step_source: assert property (@(posedge clk) disable iff (rst)
        (ts_step && !adj_active) |-> $past(ts96_load_valid || ts64_load_valid, 2))
        else begin
            $error("ts_step high without a load or an offset adjust");
            fail_cnt++;
        end

endmodule

bind ptp_clock_top ptp_clock_assert #(
    .PPS_WIDTH (PPS_WIDTH)
) u_ptp_clock_assert (
    .clk             (clk),
    .rst             (rst),
    .ts96            (ts96),
    .pps             (pps),
    .ts_step         (ts_step),
    .adj_active      (adj_active),
    .ts96_load_valid (ts96_load.valid),
    .ts64_load_valid (ts64_load.valid)
);

// File: tb/ptp_clock_tb.sv
// PTP clock testbench
// clock, reset and seeded random stimulus
// cycle model of the increment, both counters and the output stage
// compare tasks, per-test lines and the closing report

`timescale 1ns/1ps

module ptp_clock_tb;

    localparam logic [3:0]  PERIOD_NS = 4'h6;
    localparam logic [15:0] PERIOD_FNS = 16'h6666;
    localparam logic [3:0]  DRIFT_NS = 4'h0;
    localparam logic [15:0] DRIFT_FNS = 16'h0002;
    localparam logic [15:0] DRIFT_RATE = 16'd5;
    localparam int          PPS_WIDTH = 4;
    localparam int          INC_W = $bits(ptp_types_pkg::ptp_inc_t);
    localparam logic [63:0] ONE_SEC = 64'(ptp_const_pkg::NS_PER_SEC) << ptp_const_pkg::FNS_W;

    logic                           clk;
    logic                           rst;
    ptp_types_pkg::ptp_period_cmd_t period_cmd;
    ptp_types_pkg::ptp_adj_cmd_t    adj_cmd;
    ptp_types_pkg::ptp_drift_cmd_t  drift_cmd;
    ptp_types_pkg::ptp_ts96_load_t  ts96_load;
    ptp_types_pkg::ptp_ts64_load_t  ts64_load;
    ptp_types_pkg::ptp_ts96_t       ts96;
    ptp_types_pkg::ptp_ts64_t       ts64;
    logic                           ts_step;
    logic                           pps;
    logic                           adj_active;

    // strobes for the next rising edge and cleared once driven
    ptp_types_pkg::ptp_period_cmd_t nxt_period;
    ptp_types_pkg::ptp_adj_cmd_t    nxt_adj;
    ptp_types_pkg::ptp_drift_cmd_t  nxt_drift;
    ptp_types_pkg::ptp_ts96_load_t  nxt_load96;
    ptp_types_pkg::ptp_ts64_load_t  nxt_load64;

    // reference model where the plain values exclude the offset
    logic [19:0]              m_period;
    logic [19:0]              m_drift;
    logic [19:0]              m_adj;
    logic [15:0]              m_rate;
    logic [15:0]              m_drift_cnt;
    int                       m_adj_pend;
    int                       m_adj_left;
    logic [INC_W-1:0]         m_inc;
    logic [INC_W-1:0]         m_inc_plain;
    logic [63:0]              m_ns64;
    logic [63:0]              m_plain64;
    logic [63:0]              m_o64;
    logic [63:0]              m_plain_o64;
    logic [47:0]              m_sec;
    logic [45:0]              m_tod;
    logic                     m_wrap;
    logic                     m_ld96;
    logic                     m_ld64;
    logic                     m_ld_step;
    int                       m_pps_left;
    ptp_types_pkg::ptp_ts96_t m_o96;

    integer seed;
    string  test_name;
    int     errors;
    int     checks;
    int     tests;
    int     test_err0;

    ptp_clock_top #(
        .PERIOD_NS    (PERIOD_NS),
        .PERIOD_FNS   (PERIOD_FNS),
        .DRIFT_ENABLE (1'b1),
        .DRIFT_NS     (DRIFT_NS),
        .DRIFT_FNS    (DRIFT_FNS),
        .DRIFT_RATE   (DRIFT_RATE),
        .PPS_WIDTH    (PPS_WIDTH)
    ) u_ptp_clock_top (
        .clk        (clk),
        .rst        (rst),
        .period_cmd (period_cmd),
        .adj_cmd    (adj_cmd),
        .drift_cmd  (drift_cmd),
        .ts96_load  (ts96_load),
        .ts64_load  (ts64_load),
        .ts96       (ts96),
        .ts64       (ts64),
        .ts_step    (ts_step),
        .pps        (pps),
        .adj_active (adj_active)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic reset_model();
        m_period = {PERIOD_NS, PERIOD_FNS};
        m_drift = {DRIFT_NS, DRIFT_FNS};
        m_adj = '0;
        m_rate = DRIFT_RATE;
        m_drift_cnt = '0;
        m_adj_pend = 0;
        m_adj_left = 0;
        m_inc = '0;
        m_inc_plain = '0;
        m_ns64 = '0;
        m_plain64 = '0;
        m_o64 = '0;
        m_plain_o64 = '0;
        m_sec = '0;
        m_tod = '0;
        m_wrap = 1'b0;
        m_ld96 = 1'b0;
        m_ld64 = 1'b0;
        m_ld_step = 1'b0;
        m_pps_left = 0;
        m_o96 = '0;
    endtask

    // one rising edge with the inputs the DUT samples at that edge
    task automatic advance_model();
        logic        drift_now;
        logic [63:0] sum;
        drift_now = (m_drift_cnt == '0);
        // output stage registers the counters before they move
        m_o64 = m_ns64;
        m_plain_o64 = m_plain64;
        m_o96 = {m_sec, 2'b00, m_tod};
        m_ld_step = m_ld96 | m_ld64;
        if (m_wrap) begin
            m_pps_left = PPS_WIDTH;
        end else if (m_pps_left > 0) begin
            m_pps_left--;
        end
        m_ld64 = ts64_load.valid;
        m_ld96 = ts96_load.valid;
        m_wrap = 1'b0;
        if (ts64_load.valid) begin
            m_ns64 = ts64_load.ts;
            m_plain64 = ts64_load.ts;
        end else begin
            m_ns64 = m_ns64 + 64'(m_inc);
            m_plain64 = m_plain64 + 64'(m_inc_plain);
        end
        if (ts96_load.valid) begin
            m_sec = ts96_load.ts.sec;
            m_tod = {ts96_load.ts.ns, ts96_load.ts.fns};
        end else begin
            sum = 64'(m_tod) + 64'(m_inc);
            m_wrap = (sum >= ONE_SEC);
            m_sec = m_sec + 48'(m_wrap);
            m_tod = m_wrap ? 46'(sum - ONE_SEC) : 46'(sum);
        end
        // increment from period, drift and the offset while active
        m_inc_plain = INC_W'(64'(m_period) + (drift_now ? 64'(m_drift) : 64'd0));
        m_inc = INC_W'(64'(m_inc_plain) +
                       ((m_adj_left != 0) ? 64'(longint'($signed(m_adj))) : 64'd0));
        m_drift_cnt = drift_now ? m_rate - 16'd1 : m_drift_cnt - 16'd1;
        if (period_cmd.valid) begin
            m_period = {period_cmd.ns, period_cmd.fns};
        end
        if (drift_cmd.valid) begin
            m_drift = {drift_cmd.ns, drift_cmd.fns};
            m_rate = drift_cmd.rate;
        end
        if (m_adj_pend != 0) begin
            m_adj_left = m_adj_pend;
            m_adj_pend = 0;
        end else if (m_adj_left != 0) begin
            m_adj_left--;
        end
        if (adj_cmd.valid) begin
            m_adj_pend = adj_cmd.count;
            m_adj = {adj_cmd.ns, adj_cmd.fns};
        end
    endtask

    task automatic check_ts96(input string what, input ptp_types_pkg::ptp_ts96_t exp,
                              input ptp_types_pkg::ptp_ts96_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_ts64(input string what, input ptp_types_pkg::ptp_ts64_t exp,
                              input ptp_types_pkg::ptp_ts64_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s %s expected %b actual %b", test_name, what, exp, act);
        end
    endtask

    // drive pending strobes at the edge and compare at the falling edge
    task automatic run_cycle();
        @(posedge clk);
        advance_model();
        period_cmd <= nxt_period;
        adj_cmd <= nxt_adj;
        drift_cmd <= nxt_drift;
        ts96_load <= nxt_load96;
        ts64_load <= nxt_load64;
        nxt_period = '0;
        nxt_adj = '0;
        nxt_drift = '0;
        nxt_load96 = '0;
        nxt_load64 = '0;
        @(negedge clk);
        check_ts96("ts96", m_o96, ts96);
        check_ts64("ts64", m_o64, ts64);
        check_bit("pps", m_pps_left != 0, pps);
        check_bit("adj_active", m_adj_left != 0, adj_active);
        check_bit("ts_step", m_ld_step | (m_adj_left != 0), ts_step);
    endtask

    function automatic logic watched_high(input string name);
        case (name)
            "pps":        return pps;
            "adj_active": return adj_active;
            default:      return ts_step;
        endcase
    endfunction

    task automatic wait_until_high(input string name, input int limit);
        int n;
        n = 0;
        while (watched_high(name) !== 1'b1 && n < limit) begin
            run_cycle();
            n++;
        end
        if (watched_high(name) !== 1'b1) begin
            errors++;
            $display("%s: %s did not go high within %0d cycles", test_name, name, limit);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err0 = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("test %s %s, %0d errors", test_name,
                 (errors == test_err0) ? "passed" : "failed", errors - test_err0);
    endtask

    initial begin
        ptp_types_pkg::ptp_ts64_load_t load64;
        ptp_types_pkg::ptp_ts96_load_t load96;
        logic [47:0]        sec0;
        logic signed [19:0] offset;
        logic [15:0]        count;
        logic [63:0]        base;
        int                 v;
        seed = 32'he01c3667;
        errors = 0;
        checks = 0;
        tests = 0;
        rst = 1'b1;
        period_cmd = '0;
        adj_cmd = '0;
        drift_cmd = '0;
        ts96_load = '0;
        ts64_load = '0;
        nxt_period = '0;
        nxt_adj = '0;
        nxt_drift = '0;
        nxt_load96 = '0;
        nxt_load64 = '0;
        reset_model();
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        start_test("free_run");
        repeat (40) run_cycle();
        end_test();

        start_test("loads");
        load64.valid = 1'b1;
        load64.ts = {$random(seed), $random(seed)};
        load96.valid = 1'b1;
        load96.ts.sec = 48'({$random(seed), $random(seed)});
        load96.ts.pad = '0;
        load96.ts.ns = 30'({$random(seed)} % ptp_const_pkg::NS_PER_SEC);
        load96.ts.fns = 16'($random(seed));
        nxt_load64 = load64;
        nxt_load96 = load96;
        run_cycle();
        wait_until_high("ts_step", 10);
        check_ts64("loaded ts64", load64.ts, ts64);
        check_ts96("loaded ts96", load96.ts, ts96);
        run_cycle();
        check_bit("step pulse end", 1'b0, ts_step);
        repeat (10) run_cycle();
        end_test();

        // a few increments below the next second
        start_test("rollover");
        load96.ts.sec = 48'({$random(seed), $random(seed)});
        load96.ts.ns = 30'(ptp_const_pkg::NS_PER_SEC - 20);
        load96.ts.fns = '0;
        sec0 = load96.ts.sec;
        nxt_load96 = load96;
        run_cycle();
        wait_until_high("pps", 20);
        check_bit("seconds advance", 1'b1, ts96.sec == sec0 + 1'b1);
        for (int i = 1; i < PPS_WIDTH; i++) begin
            run_cycle();
            check_bit("pps width", 1'b1, pps);
        end
        run_cycle();
        check_bit("pps end", 1'b0, pps);
        repeat (5) run_cycle();
        end_test();

        start_test("period");
        nxt_period = '{valid: 1'b1, ns: 4'(3 + {$random(seed)} % 8), fns: 16'($random(seed))};
        run_cycle();
        repeat (20) run_cycle();
        end_test();

        start_test("offset");
        v = int'({$random(seed)} % 5) - 2;
        offset = {4'(v), 16'($random(seed))};
        count = 16'(1 + {$random(seed)} % 20);
        base = m_o64 - m_plain_o64;
        nxt_adj = '{valid: 1'b1, ns: offset[19:16], fns: offset[15:0], count: count};
        run_cycle();
        wait_until_high("adj_active", 10);
        for (int i = 0; i < count; i++) begin
            check_bit("adj window", 1'b1, adj_active);
            check_bit("step window", 1'b1, ts_step);
            run_cycle();
        end
        check_bit("adj window end", 1'b0, adj_active);
        check_bit("step window end", 1'b0, ts_step);
        // last offset cycle still has to pass the counter and output stage
        repeat (4) run_cycle();
        check_ts64("offset total",
                   m_plain_o64 + base + 64'(longint'(count) * longint'(offset)), ts64);
        end_test();

        start_test("drift");
        nxt_drift = '{valid: 1'b1, ns: 4'({$random(seed)} % 4), fns: 16'($random(seed)),
                      rate: 16'(2 + {$random(seed)} % 7)};
        run_cycle();
        repeat (40) run_cycle();
        end_test();

        errors = errors + u_ptp_clock_top.u_ptp_clock_assert.fail_cnt;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
